// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench and the RTL with Verilator, runs it and searches the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem -f src.f \
	&& ./obj_dir/Vtb_mem_subsystem | tee sim.log \
	|| exit 1
grep -q "^sim passed$" sim.log || exit 1
exit 0

// ==== src.f ====
+incdir+test
src/mem_pkg.sv
src/mem_port_if.sv
src/unified_memory.sv
src/dma_engine.sv
src/port_arbiter.sv
src/mem_subsystem.sv
test/tb_mem_subsystem.sv

// ==== src/boot_image.hex ====
// Boot program, one 16-bit instruction word in hex per line.
// The lines fill addresses 0 to 15 in order.
1005
2106
3012
4100
5203
6a0f
7001
8c20
9402
a0ff
b310
c004
d7e1
e00c
f800
0000

// ==== src/dma_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_engine
	import mem_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,

	input  logic      start,
	input  mem_addr_t src,
	input  mem_addr_t dst,
	input  dma_len_t  len,
	output logic      done,

	mem_port_if.requester port
);

	dma_state_t state;
	dma_len_t   remaining;
	mem_addr_t  src_q;
	mem_addr_t  dst_q;
	logic       start_ok;
	logic       last_write;

	// Starts that arrive while busy or carry a bad length are ignored.
	assign start_ok = start && (state == dma_idle) && (len != '0) && (len <= DMA_MAX_WORDS);

	assign last_write = (state == dma_write) && (remaining == dma_len_t'(1));

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state     <= dma_idle;
			remaining <= '0;
			done      <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				dma_idle:
				begin
					if (start_ok)
					begin
						state     <= dma_read;
						remaining <= len;
					end
				end
				dma_read:
				begin
					state <= dma_write;
				end
				dma_write:
				begin
					remaining <= remaining - 1'b1;
					if (last_write)
					begin
						state <= dma_idle;
						done  <= 1'b1;
					end
					else
					begin
						state <= dma_read;
					end
				end
				default:
				begin
					state <= dma_idle;
				end
			endcase
		end
	end

	// Both addresses step by one word and wrap around the array.
	always_ff @(posedge clk)
	begin
		if (start_ok)
		begin
			src_q <= src;
			dst_q <= dst;
		end
		else if (state == dma_read)
		begin
			src_q <= src_q + 1'b1;
		end
		else if (state == dma_write)
		begin
			dst_q <= dst_q + 1'b1;
		end
	end

	assign port.busy    = (state != dma_idle);
	assign port.read    = (state == dma_read);
	assign port.write   = (state == dma_write);
	assign port.address = (state == dma_write) ? dst_q : src_q;

	// The memory's read register still holds the source word during the write cycle.
	assign port.wdata = port.rdata;

	a_remaining_limit: assert property (
		@(posedge clk) disable iff (!reset_n)
		remaining <= DMA_MAX_WORDS
	)
	else $error("DMA remaining count %0d exceeds the limit", remaining);

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

// Shared widths, types and limits of the memory subsystem.
package mem_pkg;

	localparam int ADDR_WIDTH = 8;
	localparam int WORD_WIDTH = 16;

	// The array covers the whole 8-bit address space.
	localparam int MEM_DEPTH = 256;

	// Longest block copy, matching the twelve-word test window.
	localparam int DMA_MAX_WORDS = 12;

	// Boot program, loaded once at time zero and never on reset.
	localparam string BOOT_IMAGE_FILE = "src/boot_image.hex";

	typedef logic [ADDR_WIDTH-1:0] mem_addr_t;
	typedef logic [WORD_WIDTH-1:0] mem_word_t;

	// Four bits are enough for a length of up to twelve words.
	typedef logic [3:0] dma_len_t;

	// One word moves in a read cycle followed by a write cycle.
	typedef enum logic [1:0]
	{
		dma_idle,
		dma_read,
		dma_write
	} dma_state_t;

endpackage

`default_nettype wire

// ==== src/mem_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One requester's connection to data port two.
interface mem_port_if
	import mem_pkg::*;
();

	logic      read;
	logic      write;
	mem_addr_t address;
	mem_word_t wdata;
	mem_word_t rdata;

	// Held high by the DMA engine for as long as it owns the port.
	logic      busy;

	modport requester
	(
		output read,
		output write,
		output address,
		output wdata,
		output busy,
		input  rdata
	);

	modport memory
	(
		input  read,
		input  write,
		input  address,
		input  wdata,
		input  busy,
		output rdata
	);

endinterface

`default_nettype wire

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
	import mem_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,

	input  logic      fetch,
	input  mem_addr_t fetch_addr,
	output mem_word_t fetch_data,

	input  logic      host_read,
	input  logic      host_write,
	input  mem_addr_t host_addr,
	input  mem_word_t host_wdata,
	output mem_word_t host_rdata,

	input  logic      dma_start,
	input  mem_addr_t dma_src,
	input  mem_addr_t dma_dst,
	input  dma_len_t  dma_len,
	output logic      dma_busy,
	output logic      dma_done
);

	mem_port_if host_port ();
	mem_port_if dma_port ();
	mem_port_if mem_port ();

	// The host side never claims the port.
	assign host_port.read    = host_read;
	assign host_port.write   = host_write;
	assign host_port.address = host_addr;
	assign host_port.wdata   = host_wdata;
	assign host_port.busy    = 1'b0;
	assign host_rdata        = host_port.rdata;

	assign dma_busy = dma_port.busy;

	dma_engine dma_engine_i
	(
		.clk     (clk),
		.reset_n (reset_n),
		.start   (dma_start),
		.src     (dma_src),
		.dst     (dma_dst),
		.len     (dma_len),
		.done    (dma_done),
		.port    (dma_port.requester)
	);

	port_arbiter port_arbiter_i
	(
		.clk     (clk),
		.reset_n (reset_n),
		.host    (host_port.memory),
		.dma     (dma_port.memory),
		.mem     (mem_port.requester)
	);

	unified_memory unified_memory_i
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.fetch      (fetch),
		.fetch_addr (fetch_addr),
		.fetch_data (fetch_data),
		.port       (mem_port.memory)
	);

endmodule

`default_nettype wire

// ==== src/port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
(
	input  logic clk,
	input  logic reset_n,

	mem_port_if.memory    host,
	mem_port_if.memory    dma,
	mem_port_if.requester mem
);

	logic dma_owns;

	// The DMA engine owns the port for the whole transfer and host strobes are lost.
	assign dma_owns = dma.busy;

	assign mem.read    = dma_owns ? dma.read    : host.read;
	assign mem.write   = dma_owns ? dma.write   : host.write;
	assign mem.address = dma_owns ? dma.address : host.address;
	assign mem.wdata   = dma_owns ? dma.wdata   : host.wdata;

	// Nothing upstream of the memory claims the merged port.
	assign mem.busy = 1'b0;

	assign host.rdata = mem.rdata;
	assign dma.rdata  = mem.rdata;

	a_host_one_strobe: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(host.read && host.write)
	)
	else $error("Host drives read and write together");

	a_dma_one_strobe: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(dma.read && dma.write)
	)
	else $error("DMA drives read and write together");

	a_mem_one_strobe: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(mem.read && mem.write)
	)
	else $error("Memory sees read and write together");

	// While the DMA engine is busy only its own strobes may reach the array.
	a_host_blocked: assert property (
		@(posedge clk) disable iff (!reset_n)
		dma.busy |-> (mem.read == dma.read) && (mem.write == dma.write)
	)
	else $error("Host strobe reached memory during a DMA transfer");

endmodule

`default_nettype wire

// ==== src/unified_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module unified_memory
	import mem_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,

	// Port one serves instruction fetch.
	input  logic      fetch,
	input  mem_addr_t fetch_addr,
	output mem_word_t fetch_data,

	// Port two serves data reads and writes.
	mem_port_if.memory port
);

	mem_word_t mem_array [MEM_DEPTH];
	mem_word_t rdata_q;
	logic      fetch_hit;

	// The boot program is present from time zero and survives reset.
	initial
	begin
		$readmemh(BOOT_IMAGE_FILE, mem_array);
	end

	// A fetch of the word that port two writes in this cycle sees the new value.
	assign fetch_hit = port.write && (port.address == fetch_addr);

	always @(posedge clk)
	begin
		if (port.write)
		begin
			mem_array[port.address] <= port.wdata;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			fetch_data <= '0;
			rdata_q    <= '0;
		end
		else
		begin
			if (fetch)
			begin
				fetch_data <= fetch_hit ? port.wdata : mem_array[fetch_addr];
			end
			// The read word is held until the next read strobe.
			if (port.read)
			begin
				rdata_q <= mem_array[port.address];
			end
		end
	end

	assign port.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== test/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Counts a wrong value against the running test and prints it.
task automatic report_mismatch(input string name, input mem_word_t expected,
	input mem_word_t actual);
	test_errors++;
	$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
endtask

// Both read registers leave reset cleared.
a_reset_fetch: assert property (@(posedge clk) $rose(reset_n) |-> fetch_data == '0)
	else report_mismatch("fetch_data", '0, $sampled(fetch_data));

a_reset_rdata: assert property (@(posedge clk) $rose(reset_n) |-> host_rdata == '0)
	else report_mismatch("host_rdata", '0, $sampled(host_rdata));

a_fetch_data: assert property (@(posedge clk) disable iff (!reset_n)
	fetch |=> fetch_data === fetch_exp_q)
	else report_mismatch("fetch_data", $sampled(fetch_exp_q), $sampled(fetch_data));

// Host reads that arrive while the DMA engine owns the port are dropped.
a_host_rdata: assert property (@(posedge clk) disable iff (!reset_n)
	host_read && !dma_busy |=> host_rdata === read_exp_q)
	else report_mismatch("host_rdata", $sampled(read_exp_q), $sampled(host_rdata));

// An accepted copy holds dma_busy for two cycles per word, and dma_done pulses as it falls.
a_dma_busy: assert property (@(posedge clk) disable iff (!reset_n)
	dma_busy === (done_wait > 1))
	else report_mismatch("dma_busy", mem_word_t'($sampled(done_wait) > 1),
		mem_word_t'($sampled(dma_busy)));

a_dma_done: assert property (@(posedge clk) disable iff (!reset_n)
	dma_done === (done_wait == 1))
	else report_mismatch("dma_done", mem_word_t'($sampled(done_wait) == 1),
		mem_word_t'($sampled(dma_done)));

`endif

// ==== test/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
	import mem_pkg::*;
();

	localparam int WRITE_ROUNDS = 64;
	localparam int FORWARD_ROUNDS = 32;
	localparam int DMA_COPIES = 30;

	// Reset and boot fetches, two cycles per round, up to 40 cycles per copy, and a margin
	// for the blocked-write and bad-length tests.
	localparam int TEST_CYCLES = 30 + 2 * (WRITE_ROUNDS + FORWARD_ROUNDS)
		+ DMA_COPIES * (3 * DMA_MAX_WORDS + 4) + 100;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic      clk = 1'b0;
	logic      reset_n = 1'b0;
	logic      fetch = 1'b0;
	mem_addr_t fetch_addr = '0;
	mem_word_t fetch_data;
	logic      host_read = 1'b0;
	logic      host_write = 1'b0;
	mem_addr_t host_addr = '0;
	mem_word_t host_wdata = '0;
	mem_word_t host_rdata;
	logic      dma_start = 1'b0;
	mem_addr_t dma_src = '0;
	mem_addr_t dma_dst = '0;
	dma_len_t  dma_len = '0;
	logic      dma_busy;
	logic      dma_done;

	mem_word_t model [MEM_DEPTH];
	mem_word_t fetch_exp = '0;
	mem_word_t read_exp = '0;
	mem_word_t fetch_exp_q;
	mem_word_t read_exp_q;
	int        done_wait;
	int        cycles = 0;
	int        test_errors = 0;
	int        tests_passed = 0;
	int        tests_failed = 0;

	mem_subsystem mem_subsystem_i (.*);

	always #20 clk = ~clk;

	// Expected words move to the edge where the DUT shows them, and done_wait counts down
	// to the edge where an accepted copy should report dma_done.
	always @(posedge clk)
	begin
		fetch_exp_q <= fetch_exp;
		read_exp_q  <= read_exp;
		cycles      <= cycles + 1;
		if (!reset_n)
			done_wait <= 0;
		else if (dma_start && (done_wait <= 1) && dma_len != '0 && dma_len <= DMA_MAX_WORDS)
			done_wait <= 2 * int'(dma_len) + 1;
		else if (done_wait > 0)
			done_wait <= done_wait - 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	`include "tb_checks.svh"

	task automatic settle(input int n);
		repeat (n)
		begin
			@(negedge clk);
			fetch      = 1'b0;
			host_read  = 1'b0;
			host_write = 1'b0;
			dma_start  = 1'b0;
		end
	endtask

	// Drives one cycle of fetch and host traffic and notes the words it should return.
	task automatic issue(input logic f, input mem_addr_t fa, input logic r, input logic w,
		input mem_addr_t ha, input mem_word_t hd);
		logic write_ok;
		@(negedge clk);
		write_ok   = w && (done_wait <= 1);
		fetch      = f;
		fetch_addr = fa;
		host_read  = r;
		host_write = w;
		host_addr  = ha;
		host_wdata = hd;
		dma_start  = 1'b0;
		fetch_exp  = (write_ok && ha == fa) ? hd : model[fa];
		read_exp   = model[ha];
		if (write_ok)
			model[ha] = hd;
	endtask

	task automatic launch_dma(input mem_addr_t s, input mem_addr_t d, input dma_len_t l);
		settle(1);
		dma_start = 1'b1;
		dma_src   = s;
		dma_dst   = d;
		dma_len   = l;
		// Word by word, so an overlapping copy reads what it already wrote.
		if ((done_wait <= 1) && l != '0 && l <= DMA_MAX_WORDS)
			for (int i = 0; i < int'(l); i++)
				model[mem_addr_t'(d + i)] = model[mem_addr_t'(s + i)];
	endtask

	task automatic wait_dma_done();
		do
			settle(1);
		while (!dma_done);
	endtask

	task automatic finish_test(input string name);
		settle(2);
		$display("Test %s: %0d errors", name, test_errors);
		if (test_errors == 0)
			tests_passed++;
		else
			tests_failed++;
		test_errors = 0;
	endtask

	initial
	begin
		mem_addr_t a;
		mem_addr_t b;
		mem_addr_t d;
		dma_len_t  l;
		mem_addr_t blocked [$];

		void'($urandom(32'hd5bc2022));
		$readmemh(BOOT_IMAGE_FILE, model);
		repeat (8) @(negedge clk);
		reset_n = 1'b1;

		for (int i = 0; i < 16; i++)
			issue(1'b1, mem_addr_t'(i), 1'b0, 1'b0, '0, '0);
		finish_test("reset and boot fetch");

		repeat (WRITE_ROUNDS)
		begin
			a = mem_addr_t'($urandom);
			issue(1'b0, '0, 1'b0, 1'b1, a, mem_word_t'($urandom));
			issue(1'b1, a, 1'b1, 1'b0, a, '0);
		end
		finish_test("host write and read back");

		repeat (FORWARD_ROUNDS)
		begin
			a = mem_addr_t'($urandom);
			// flipping at least one bit always gives another address
			b = a ^ mem_addr_t'(1 + $urandom % 255);
			issue(1'b1, a, 1'b0, 1'b1, a, mem_word_t'($urandom));
			issue(1'b1, b, 1'b0, 1'b1, a, mem_word_t'($urandom));
		end
		finish_test("fetch forwarding");

		repeat (DMA_COPIES)
		begin
			d = mem_addr_t'($urandom);
			l = dma_len_t'(1 + $urandom % DMA_MAX_WORDS);
			launch_dma(mem_addr_t'($urandom), d, l);
			wait_dma_done();
			for (int i = 0; i < int'(l); i++)
				issue(1'b1, mem_addr_t'(d + i), 1'b0, 1'b0, '0, '0);
		end
		finish_test("dma copy");

		d = mem_addr_t'($urandom);
		launch_dma(mem_addr_t'($urandom), d, dma_len_t'(DMA_MAX_WORDS));
		for (int i = 0; i < 6; i++)
		begin
			a = mem_addr_t'($urandom);
			blocked.push_back(a);
			issue(1'b0, '0, 1'b0, 1'b1, a, mem_word_t'($urandom));
		end
		// A start in the middle of a copy is ignored.
		launch_dma(mem_addr_t'($urandom), mem_addr_t'($urandom), dma_len_t'(5));
		wait_dma_done();
		foreach (blocked[i])
			issue(1'b1, blocked[i], 1'b0, 1'b0, '0, '0);
		for (int i = 0; i < DMA_MAX_WORDS; i++)
			issue(1'b1, mem_addr_t'(d + i), 1'b0, 1'b0, '0, '0);
		finish_test("host blocked during dma");

		for (int i = 0; i < 4; i++)
		begin
			l = (i == 0) ? dma_len_t'(0) : dma_len_t'(DMA_MAX_WORDS + i);
			launch_dma(mem_addr_t'($urandom), mem_addr_t'($urandom), l);
			settle(4);
		end
		finish_test("bad dma length");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
